// File: logic/dcache_geom_pkg.sv
// Address split and line layout of the data cache, imported by every cache module
package dcache_geom_pkg;

  // Physical address fields, tag on top and byte offset at the bottom
  localparam int addr_w   = 15;
  localparam int tag_w    = 6;
  localparam int index_w  = 5;
  localparam int offset_w = 4;

  // Direct mapped, one line per index
  localparam int n_lines = 32;

  // A line is stored as four 32-bit words, one per bank
  localparam int n_banks = 4;
  localparam int line_w  = 128;

  // One cache line, seen two ways
  // Bytes view: byte enables of the write merge
  // Words view: split across the banks and word select on reads
  typedef union packed {
    logic [line_w/8-1:0][7:0]  bytes;
    logic [n_banks-1:0][31:0]  words;
  } dc_line_u;

endpackage

// File: logic/dcache_bus_pkg.sv
// Request and operation types passed between the requesters, arbiter and control path
package dcache_bus_pkg;

  // Access size, always naturally aligned
  typedef enum logic [1:0] {
    dc_byte = 2'd0,
    dc_half = 2'd1,
    dc_word = 2'd2
  } dc_size_e;

  // One load or store request as the requester presents it
  // wdata is ignored for loads
  typedef struct packed {
    logic [dcache_geom_pkg::addr_w-1:0] addr;
    dc_size_e                           size;
    logic [31:0]                        wdata;
  } dc_req_s;

  // The operation currently owned by the cache
  typedef struct packed {
    logic    valid;
    logic    is_wr;
    dc_req_s req;
  } dc_op_s;

endpackage

// File: logic/dc_arbiter.sv
// Grants the load or store port and holds the winning request until the cache reports done
module dc_arbiter
  import dcache_geom_pkg::*;
  import dcache_bus_pkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  logic    rd_req,
  input  dc_req_s rd_info,
  input  logic    wr_req,
  input  dc_req_s wr_info,
  input  logic    wr_urgent,
  input  logic    done,
  output dc_op_s  op,
  output logic    busy
);

  logic    valid_q;
  logic    is_wr_q;
  dc_req_s req_q;
  logic    grant_rd;
  logic    grant_wr;

  // Loads first, unless the write buffer is close to full
  assign grant_wr = wr_req && (wr_urgent || !rd_req);
  assign grant_rd = rd_req && !grant_wr;

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= 1'b0;
      is_wr_q <= 1'b0;
    end else if (valid_q) begin
      if (done) begin
        valid_q <= 1'b0;
      end
    end else if (grant_rd || grant_wr) begin
      valid_q <= 1'b1;
      is_wr_q <= grant_wr;
    end
  end

  // Request fields only captured while idle, stable for the whole operation
  always_ff @(posedge clk) begin
    if (!valid_q) begin
      req_q <= grant_wr ? wr_info : rd_info;
    end
  end

  assign op.valid = valid_q;
  assign op.is_wr = is_wr_q;
  assign op.req   = req_q;

  // Busy through the done cycle, no new grant until then
  assign busy = valid_q;

endmodule

// File: logic/dc_ctrl.sv
// Tag store and miss handling, decides hit or miss for the current operation and runs the fill
module dc_ctrl
  import dcache_geom_pkg::*;
  import dcache_bus_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  dc_op_s            op,
  input  logic              miss_ack,
  output logic              hit,
  output logic              fill,
  output logic              done,
  output logic              miss,
  output logic [addr_w-1:0] miss_addr,
  output logic              evict,
  output logic [addr_w-1:0] evict_addr
);

  // Per line state
  logic [tag_w-1:0]   tag_q [n_lines];
  logic [n_lines-1:0] valid_q;
  logic [n_lines-1:0] dirty_q;

  logic [tag_w-1:0]   op_tag;
  logic [index_w-1:0] op_index;
  logic [tag_w-1:0]   victim_tag;
  logic               tag_match;
  logic               store_hit;

  assign op_tag   = op.req.addr[addr_w-1 -: tag_w];
  assign op_index = op.req.addr[offset_w +: index_w];

  assign victim_tag = tag_q[op_index];
  assign tag_match  = valid_q[op_index] && (victim_tag == op_tag);

  // Hit check against the indexed entry
  assign hit  = op.valid && tag_match;
  assign miss = op.valid && !tag_match;

  // A hit always finishes the operation
  assign done = hit;

  // Write back only a line that is both valid and modified
  assign evict = miss && valid_q[op_index] && dirty_q[op_index];

  // Line-aligned addresses for the memory side
  assign miss_addr  = {op_tag, op_index, {offset_w{1'b0}}};
  assign evict_addr = {victim_tag, op_index, {offset_w{1'b0}}};

  // Memory returned the line, the banks take it at this edge
  assign fill = miss && miss_ack;

  assign store_hit = hit && op.is_wr;

  // Valid and dirty bits
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (fill) begin
      valid_q[op_index] <= 1'b1;
      // New line starts clean, the old one went out with evict
      dirty_q[op_index] <= 1'b0;
    end else if (store_hit) begin
      dirty_q[op_index] <= 1'b1;
    end
  end

  // Tag written on the fill edge
  always_ff @(posedge clk) begin
    if (fill) begin
      tag_q[op_index] <= op_tag;
    end
  end

endmodule

// File: logic/dc_wr_merge.sv
// Turns a store hit or a line fill into per-bank write enables, byte enables and data
module dc_wr_merge
  import dcache_geom_pkg::*;
  import dcache_bus_pkg::*;
(
  input  dc_op_s                   op,
  input  logic                     hit,
  input  logic                     fill,
  input  dc_line_u                 fill_data,
  output logic [n_banks-1:0]       bank_we,
  output logic [n_banks-1:0][3:0]  bank_be,
  output dc_line_u                 bank_wdata
);

  logic [offset_w-1:0] offset;
  logic [3:0]          size_mask;
  logic [line_w/8-1:0] line_be;
  logic [31:0]         lane_data;
  logic                store_hit;

  assign offset    = op.req.addr[offset_w-1:0];
  assign store_hit = hit && op.is_wr;

  always_comb begin
    case (op.req.size)
      dc_byte: size_mask = 4'b0001;
      dc_half: size_mask = 4'b0011;
      default: size_mask = 4'b1111;
    endcase
  end

  // Byte enables over the whole line, aligned access stays in one word
  assign line_be = {{(line_w/8-4){1'b0}}, size_mask} << offset;

  // Store data moved to its byte lane
  assign lane_data = op.req.wdata << {offset[1:0], 3'b000};

  always_comb begin
    for (int b = 0; b < line_w / 8; b++) begin
      if (fill) begin
        bank_wdata.bytes[b] = fill_data.bytes[b];
        bank_be[b/4][b%4]   = 1'b1;
      end else begin
        bank_wdata.bytes[b] = lane_data[8*(b%4) +: 8];
        bank_be[b/4][b%4]   = store_hit && line_be[b];
      end
    end
  end

  // A bank writes only when one of its bytes is enabled
  always_comb begin
    for (int w = 0; w < n_banks; w++) begin
      bank_we[w] = |bank_be[w];
    end
  end

endmodule

// File: logic/dc_data_bank.sv
// One word of every cache line, read asynchronously by index and written by byte at the clock
module dc_data_bank
  import dcache_geom_pkg::*;
(
  input  logic               clk,
  input  logic [index_w-1:0] index,
  input  logic               we,
  input  logic [3:0]         be,
  input  logic [31:0]        wdata,
  output logic [31:0]        rdata
);

  logic [3:0][7:0] mem [n_lines];

  always_ff @(posedge clk) begin
    if (we) begin
      for (int b = 0; b < 4; b++) begin
        if (be[b]) begin
          mem[index][b] <= wdata[8*b +: 8];
        end
      end
    end
  end

  // Combinational read, same index as the write
  assign rdata = mem[index];

endmodule

// File: logic/dc_rd_align.sv
// Picks the addressed word of the line and returns the load data right-aligned and zero-extended
module dc_rd_align
  import dcache_geom_pkg::*;
  import dcache_bus_pkg::*;
(
  input  dc_op_s      op,
  input  dc_line_u    bank_rdata,
  output logic [31:0] rd_data
);

  logic [offset_w-1:0] offset;
  logic [31:0]         word;
  logic [31:0]         shifted;

  assign offset = op.req.addr[offset_w-1:0];

  // Word select by offset bits 3:2
  assign word = bank_rdata.words[offset[3:2]];

  // Bring the addressed byte down to bit 0
  assign shifted = word >> {offset[1:0], 3'b000};

  always_comb begin
    case (op.req.size)
      dc_byte: rd_data = {24'd0, shifted[7:0]};
      dc_half: rd_data = {16'd0, shifted[15:0]};
      default: rd_data = shifted;
    endcase
  end

endmodule

// File: logic/dcache_top.sv
// Data cache top level, connects the arbiter, control, write merge, word banks and read aligner
module dcache_top
  import dcache_geom_pkg::*;
  import dcache_bus_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              rd_req,
  input  dc_req_s           rd_info,
  input  logic              wr_req,
  input  dc_req_s           wr_info,
  input  logic              wr_urgent,
  input  dc_line_u          fill_data,
  input  logic              miss_ack,
  output logic [31:0]       rd_data,
  output logic              rd_ready,
  output logic              wr_done,
  output logic              busy,
  output logic              miss,
  output logic [addr_w-1:0] miss_addr,
  output logic              evict,
  output logic [addr_w-1:0] evict_addr,
  output dc_line_u          evict_data
);

  dc_op_s                  op;
  logic                    hit;
  logic                    fill;
  logic                    done;
  logic [n_banks-1:0]      bank_we;
  logic [n_banks-1:0][3:0] bank_be;
  dc_line_u                bank_wdata;
  wire dc_line_u           bank_rdata;

  dc_arbiter u_arbiter (
    .clk       (clk),
    .reset     (reset),
    .rd_req    (rd_req),
    .rd_info   (rd_info),
    .wr_req    (wr_req),
    .wr_info   (wr_info),
    .wr_urgent (wr_urgent),
    .done      (done),
    .op        (op),
    .busy      (busy)
  );

  dc_ctrl u_ctrl (
    .clk        (clk),
    .reset      (reset),
    .op         (op),
    .miss_ack   (miss_ack),
    .hit        (hit),
    .fill       (fill),
    .done       (done),
    .miss       (miss),
    .miss_addr  (miss_addr),
    .evict      (evict),
    .evict_addr (evict_addr)
  );

  dc_wr_merge u_wr_merge (
    .op         (op),
    .hit        (hit),
    .fill       (fill),
    .fill_data  (fill_data),
    .bank_we    (bank_we),
    .bank_be    (bank_be),
    .bank_wdata (bank_wdata)
  );

  // One bank per word of the line
  for (genvar g = 0; g < n_banks; g++) begin : g_bank
    dc_data_bank u_bank (
      .clk   (clk),
      .index (op.req.addr[offset_w +: index_w]),
      .we    (bank_we[g]),
      .be    (bank_be[g]),
      .wdata (bank_wdata.words[g]),
      .rdata (bank_rdata.words[g])
    );
  end

  dc_rd_align u_rd_align (
    .op         (op),
    .bank_rdata (bank_rdata),
    .rd_data    (rd_data)
  );

  // Victim line is still in the banks while the miss is open
  assign evict_data = bank_rdata;

  assign rd_ready = done && !op.is_wr;
  assign wr_done  = done && op.is_wr;

endmodule

// File: verif/dcache_tb.sv
// Self-checking testbench for the data cache, random loads and stores against a reference model
module dcache_tb
  import dcache_geom_pkg::*;
  import dcache_bus_pkg::*;
();

  localparam int n_ops          = 2000;
  localparam int timeout_cycles = n_ops * 16 + 100;
  localparam int reset_cycles   = 16;
  localparam int mem_bytes      = 1 << addr_w;

  logic              clk;
  logic              reset;
  logic              rd_req;
  dc_req_s           rd_info;
  logic              wr_req;
  dc_req_s           wr_info;
  logic              wr_urgent;
  dc_line_u          fill_data;
  logic              miss_ack;
  logic [31:0]       rd_data;
  logic              rd_ready;
  logic              wr_done;
  logic              busy;
  logic              miss;
  logic [addr_w-1:0] miss_addr;
  logic              evict;
  logic [addr_w-1:0] evict_addr;
  dc_line_u          evict_data;

  // Backing memory behind the cache, and the architectural reference
  logic [7:0] mem_model [mem_bytes];
  logic [7:0] ref_mem   [mem_bytes];

  // Shadow tag store, predicts hit, miss and evict
  logic [tag_w-1:0]   sh_tag [n_lines];
  logic [n_lines-1:0] sh_valid;
  logic [n_lines-1:0] sh_dirty;

  // Predicted operation state, kept across rounds
  logic        in_flight;
  logic        done_exp;

  logic [31:0] lfsr;
  int          cycle_count = 0;
  int          ops_done;
  int          miss_count;
  int          evict_count;

  dcache_top dut (
    .clk        (clk),
    .reset      (reset),
    .rd_req     (rd_req),
    .rd_info    (rd_info),
    .wr_req     (wr_req),
    .wr_info    (wr_info),
    .wr_urgent  (wr_urgent),
    .fill_data  (fill_data),
    .miss_ack   (miss_ack),
    .rd_data    (rd_data),
    .rd_ready   (rd_ready),
    .wr_done    (wr_done),
    .busy       (busy),
    .miss       (miss),
    .miss_addr  (miss_addr),
    .evict      (evict),
    .evict_addr (evict_addr),
    .evict_data (evict_data)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("Timeout, the run did not finish within %0d cycles", timeout_cycles);
      $display("test failed");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
      $display("test failed");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r    = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return r;
  endfunction

  function automatic int size_bytes(input dc_size_e size);
    case (size)
      dc_byte: return 1;
      dc_half: return 2;
      default: return 4;
    endcase
  endfunction

  function automatic dc_req_s random_req();
    dc_req_s             r;
    logic [31:0]         t;
    logic [offset_w-1:0] off;
    t = rand_bits(2);
    // Four tags per index, spread over all tag bits
    r.addr[addr_w-1 -: tag_w] = {t[1:0], t[1:0], t[1:0]};
    t = rand_bits(index_w);
    r.addr[offset_w +: index_w] = t[index_w-1:0];
    t = rand_bits(2);
    case (t[1:0])
      2'd0:    r.size = dc_byte;
      2'd1:    r.size = dc_half;
      default: r.size = dc_word;
    endcase
    t = rand_bits(offset_w);
    off = t[offset_w-1:0];
    // Natural alignment
    if (r.size == dc_half) begin
      off[0] = 1'b0;
    end else if (r.size == dc_word) begin
      off[1:0] = 2'b00;
    end
    r.addr[offset_w-1:0] = off;
    r.wdata = rand_bits(32);
    return r;
  endfunction

  function automatic dc_line_u ref_line(input logic [addr_w-1:0] addr);
    dc_line_u l;
    for (int b = 0; b < line_w / 8; b++) begin
      l.bytes[b] = ref_mem[{addr[addr_w-1:offset_w], offset_w'(b)}];
    end
    return l;
  endfunction

  function automatic dc_line_u model_line(input logic [addr_w-1:0] addr);
    dc_line_u l;
    for (int b = 0; b < line_w / 8; b++) begin
      l.bytes[b] = mem_model[{addr[addr_w-1:offset_w], offset_w'(b)}];
    end
    return l;
  endfunction

  // Reference bytes at the address, zero-extended to 32 bits
  function automatic logic [31:0] expected_load(input dc_req_s req);
    logic [31:0]       v;
    logic [addr_w-1:0] a;
    v = '0;
    for (int k = 0; k < size_bytes(req.size); k++) begin
      a = req.addr + addr_w'(k);
      v[8*k +: 8] = ref_mem[a];
    end
    return v;
  endfunction

  task automatic store_ref(input dc_req_s req);
    logic [addr_w-1:0] a;
    for (int k = 0; k < size_bytes(req.size); k++) begin
      a = req.addr + addr_w'(k);
      ref_mem[a] = req.wdata[8*k +: 8];
    end
  endtask

  task automatic write_back(input logic [addr_w-1:0] addr, input dc_line_u data);
    for (int b = 0; b < line_w / 8; b++) begin
      mem_model[{addr[addr_w-1:offset_w], offset_w'(b)}] = data.bytes[b];
    end
  endtask

  // Same pattern in both memories, mixed with the full address
  task automatic init_memories();
    logic [addr_w-1:0] a;
    logic [31:0]       t;
    logic [7:0]        v;
    for (int i = 0; i < mem_bytes; i++) begin
      a = addr_w'(i);
      t = rand_bits(8);
      v = t[7:0] ^ a[7:0] ^ {1'b0, a[addr_w-1:8]};
      mem_model[a] = v;
      ref_mem[a]   = v;
    end
  endtask

  task automatic check_quiet();
    check_value("rd_ready", 128'(rd_ready), 128'(0));
    check_value("wr_done", 128'(wr_done), 128'(0));
    check_value("miss", 128'(miss), 128'(0));
    check_value("evict", 128'(evict), 128'(0));
  endtask

  // One round is a load, a store, or both at once to exercise the priority
  task automatic run_round();
    dc_req_s            rreq;
    dc_req_s            wreq;
    dc_req_s            cur;
    logic [31:0]        t;
    logic               rd_pend;
    logic               wr_pend;
    logic               urgent;
    logic               cur_wr;
    logic               granted;
    logic               waiting;
    logic               evict_exp;
    logic [tag_w-1:0]   tag;
    logic [index_w-1:0] idx;
    logic [addr_w-1:0]  line_addr;
    logic [addr_w-1:0]  victim_addr;
    int                 delay;
    t = rand_bits(2);
    rd_pend = (t[1:0] != 2'd1);
    wr_pend = (t[1:0] != 2'd0);
    t = rand_bits(1);
    urgent = t[0];
    rreq = random_req();
    wreq = random_req();
    rd_req    = rd_pend;
    rd_info   = rreq;
    wr_req    = wr_pend;
    wr_info   = wreq;
    wr_urgent = wr_pend && urgent;
    granted   = 1'b0;
    waiting   = 1'b0;
    evict_exp = 1'b0;
    cur_wr    = 1'b0;
    cur       = '0;
    tag       = '0;
    idx       = '0;
    line_addr = '0;
    victim_addr = '0;
    delay     = 0;
    while (rd_pend || wr_pend) begin
      @(negedge clk);
      miss_ack = 1'b0;
      // Idle before the last edge with a request pending, so granted there
      granted   = !in_flight;
      in_flight = !in_flight || !done_exp;
      done_exp  = 1'b0;
      check_value("busy", 128'(busy), 128'(in_flight));
      if (!in_flight) begin
        check_quiet();
      end else begin
        if (granted) begin
          // Read first unless the write is urgent
          cur_wr      = wr_pend && (urgent || !rd_pend);
          cur         = cur_wr ? wreq : rreq;
          tag         = cur.addr[addr_w-1 -: tag_w];
          idx         = cur.addr[offset_w +: index_w];
          line_addr   = {tag, idx, {offset_w{1'b0}}};
          victim_addr = {sh_tag[idx], idx, {offset_w{1'b0}}};
          waiting     = !(sh_valid[idx] && sh_tag[idx] == tag);
          evict_exp   = waiting && sh_valid[idx] && sh_dirty[idx];
          if (waiting) begin
            t = rand_bits(3);
            delay = int'(t[2:0]) + 1;
            miss_count++;
          end
          if (evict_exp) begin
            evict_count++;
          end
        end
        if (waiting) begin
          check_value("miss", 128'(miss), 128'(1));
          check_value("miss_addr", 128'(miss_addr), 128'(line_addr));
          check_value("evict", 128'(evict), 128'(evict_exp));
          check_value("rd_ready", 128'(rd_ready), 128'(0));
          check_value("wr_done", 128'(wr_done), 128'(0));
          if (evict_exp) begin
            check_value("evict_addr", 128'(evict_addr), 128'(victim_addr));
            check_value("evict_data", 128'(evict_data), 128'(ref_line(victim_addr)));
          end
          delay--;
          if (delay == 0) begin
            // Memory answers: take the victim, return the new line
            if (evict_exp) begin
              write_back(victim_addr, evict_data);
            end
            fill_data     = model_line(line_addr);
            miss_ack      = 1'b1;
            sh_tag[idx]   = tag;
            sh_valid[idx] = 1'b1;
            sh_dirty[idx] = 1'b0;
            waiting       = 1'b0;
          end
        end else begin
          check_value("miss", 128'(miss), 128'(0));
          check_value("evict", 128'(evict), 128'(0));
          check_value("rd_ready", 128'(rd_ready), 128'(!cur_wr));
          check_value("wr_done", 128'(wr_done), 128'(cur_wr));
          if (cur_wr) begin
            store_ref(cur);
            sh_dirty[idx] = 1'b1;
            wr_pend   = 1'b0;
            wr_req    = 1'b0;
            wr_urgent = 1'b0;
          end else begin
            check_value("rd_data", 128'(rd_data), 128'(expected_load(cur)));
            rd_pend = 1'b0;
            rd_req  = 1'b0;
          end
          done_exp = 1'b1;
          ops_done++;
        end
      end
    end
  endtask

  initial begin
    clk         = 1'b0;
    reset       = 1'b1;
    rd_req      = 1'b0;
    rd_info     = '0;
    wr_req      = 1'b0;
    wr_info     = '0;
    wr_urgent   = 1'b0;
    fill_data   = '0;
    miss_ack    = 1'b0;
    lfsr        = 32'h9a95_9369;
    ops_done    = 0;
    miss_count  = 0;
    evict_count = 0;
    in_flight   = 1'b0;
    done_exp    = 1'b0;
    sh_valid    = '0;
    sh_dirty    = '0;
    init_memories();
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    check_quiet();
    check_value("busy", 128'(busy), 128'(0));
    reset = 1'b0;
    @(negedge clk);
    check_quiet();
    check_value("busy", 128'(busy), 128'(0));
    while (ops_done < n_ops) begin
      run_round();
    end
    // Every line went through a first-access miss and a fill
    check_value("sh_valid", 128'(sh_valid), 128'({n_lines{1'b1}}));
    $display("%0d operations, %0d misses, %0d write-backs", ops_done, miss_count, evict_count);
    $display("test passed");
    $finish;
  end

endmodule

// File: dcache_top.f
logic/dcache_geom_pkg.sv
logic/dcache_bus_pkg.sv
logic/dc_arbiter.sv
logic/dc_ctrl.sv
logic/dc_wr_merge.sv
logic/dc_data_bank.sv
logic/dc_rd_align.sv
logic/dcache_top.sv
verif/dcache_tb.sv

// File: Makefile
TOP = dcache_tb

sim:
	verilator --binary --timing -f dcache_top.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -qx "test passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
